// ==== filelist.f ====
src/rvx_pkg.sv
src/rvx_alu.sv
src/rvx_integer_file.sv
src/rvx_decoder.sv
src/rvx_next_pc.sv
src/rvx_bus_controller.sv
src/rvx_core.sv
verif/rvx_core_assertions.sv
verif/rvx_core_tb.sv

// ==== Bender.yml ====
package:
  name: rvx_core

sources:
  - src/rvx_pkg.sv
  - src/rvx_alu.sv
  - src/rvx_integer_file.sv
  - src/rvx_decoder.sv
  - src/rvx_next_pc.sv
  - src/rvx_bus_controller.sv
  - src/rvx_core.sv
  - target: simulation
    files:
      - verif/rvx_core_assertions.sv
      - verif/rvx_core_tb.sv

// ==== verif/rvx_core_tb.sv ====
/* RVX core testbench */
`timescale 1ns/10ps

module rvx_core_tb
  import rvx_pkg::*;
;

  typedef struct packed {
    word_t   address;
    strobe_t strobe;
    word_t   data;
  } store_t;

  localparam word_t final_address = 32'd252;

  logic    clock;
  logic    reset_n;
  word_t   ibus_rdata;
  logic    ibus_rresponse;
  word_t   ibus_address;
  logic    ibus_rrequest;
  logic    dbus_wresponse;
  word_t   dbus_address;
  word_t   dbus_wdata;
  strobe_t dbus_wstrobe;
  logic    dbus_wrequest;

  logic [31:0] lfsr_state;
  word_t       program_words [0:63];
  word_t       model_regs [0:31];
  word_t       expected_fetches [$];
  store_t      expected_stores [$];
  int          fetch_count;
  int          fetch_index;
  int          store_count;
  int          ibus_wait;
  int          dbus_wait;
  logic        dbus_busy;
  int          wait_cycles;

  rvx_core #(
    .BOOT_ADDRESS (32'h0)
  ) i_dut (
    .clock          (clock),
    .reset_n        (reset_n),
    .ibus_rdata     (ibus_rdata),
    .ibus_rresponse (ibus_rresponse),
    .ibus_address   (ibus_address),
    .ibus_rrequest  (ibus_rrequest),
    .dbus_wresponse (dbus_wresponse),
    .dbus_address   (dbus_address),
    .dbus_wdata     (dbus_wdata),
    .dbus_wstrobe   (dbus_wstrobe),
    .dbus_wrequest  (dbus_wrequest)
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  task automatic report_failure(input string message);
    $display("%s", message);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int n = 0; n < count; n++) begin
      value = {value[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return value;
  endfunction

  // Program generation
  // -----------------------------------------------
  function automatic word_t make_instruction(input int index);
    logic [3:0]  kind;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] offset;
    logic [11:0] imm;
    logic        alt;
    logic [19:0] upper;
    word_t       word;
    kind   = rand_bits(4);
    funct3 = rand_bits(3);
    rd     = rand_bits(3);
    rs1    = rand_bits(3);
    rs2    = rand_bits(3);
    // Forward only, so the program always reaches its end
    offset = (1 + (rand_bits(8) % (63 - index))) * 4;
    if (kind <= 5) begin
      alt  = rand_bits(1);
      word = {1'b0, alt & (funct3 == 3'd0 || funct3 == 3'd5), 5'd0,
              rs2, rs1, funct3, rd, opcode_op};
    end else if (kind <= 9) begin
      imm = rand_bits(12);
      if (funct3 == 3'd1) begin
        imm = {7'd0, imm[4:0]};
      end else if (funct3 == 3'd5) begin
        imm = {1'b0, imm[10], 5'd0, imm[4:0]};
      end
      word = {imm, rs1, funct3, rd, opcode_op_imm};
    end else if (kind <= 11) begin
      upper = rand_bits(20);
      word  = {upper, rd, (kind == 10) ? opcode_lui : opcode_auipc};
    end else if (kind == 12) begin
      if (funct3 == 3'd2 || funct3 == 3'd3) begin
        funct3 = {2'b00, funct3[0]};
      end
      word = {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
              opcode_branch};
    end else if (kind == 13) begin
      word = {offset[20], offset[10:1], offset[11], offset[19:12], rd, opcode_jal};
    end else if (kind == 14) begin
      offset = offset + index * 4;
      word = {offset[11:0], 5'd0, 3'd0, rd, opcode_jalr};
    end else begin
      funct3 = (funct3[1:0] == 2'd3) ? 3'd2 : {1'b0, funct3[1:0]};
      imm = 12'h100 + (rand_bits(8) << 2);
      if (funct3 == 3'd0) begin
        imm[1:0] = rand_bits(2);
      end else if (funct3 == 3'd1) begin
        imm[1] = rand_bits(1);
      end
      word = {imm[11:5], rs2, 5'd0, funct3, imm[4:0], opcode_store};
    end
    return word;
  endfunction

  // Instruction-set model
  // -----------------------------------------------
  function automatic word_t alu_model(input logic [2:0] funct3, input logic alt,
                                      input word_t a, input word_t b);
    case (funct3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic run_model();
    rv_instr_u ins;
    word_t     pc;
    word_t     a;
    word_t     b;
    word_t     i_imm;
    word_t     b_imm;
    word_t     j_imm;
    word_t     s_addr;
    logic      taken;
    store_t    store;
    pc = 32'h0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int step = 0; step < 100 && pc != final_address; step++) begin
      expected_fetches.push_back(pc);
      ins   = program_words[pc[7:2]];
      a     = model_regs[ins.r.rs1];
      b     = model_regs[ins.r.rs2];
      i_imm = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
      b_imm = {{20{ins.b.imm_12}}, ins.b.imm_11, ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
      j_imm = {{12{ins.j.imm_20}}, ins.j.imm_19_12, ins.j.imm_11, ins.j.imm_10_1, 1'b0};
      case (ins.r.opcode)
        opcode_op: model_regs[ins.r.rd] = alu_model(ins.r.funct3, ins.r.funct7[5], a, b);
        opcode_op_imm: model_regs[ins.i.rd] =
          alu_model(ins.i.funct3, ins.i.funct3 == 3'd5 && i_imm[10], a, i_imm);
        opcode_lui:   model_regs[ins.u.rd] = {ins.u.imm_31_12, 12'h0};
        opcode_auipc: model_regs[ins.u.rd] = pc + {ins.u.imm_31_12, 12'h0};
        opcode_store: begin
          s_addr = a + {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
          store.address = {s_addr[31:2], 2'b00};
          store.strobe  = ((ins.s.funct3 == 3'd0) ? 4'b0001 :
                           (ins.s.funct3 == 3'd1) ? 4'b0011 : 4'b1111) << s_addr[1:0];
          store.data    = b << (8 * s_addr[1:0]);
          expected_stores.push_back(store);
        end
        default: ;
      endcase
      case (ins.r.opcode)
        opcode_jal: begin
          model_regs[ins.j.rd] = pc + 4;
          pc = pc + j_imm;
        end
        opcode_jalr: begin
          model_regs[ins.i.rd] = pc + 4;
          pc = (a + i_imm) & ~32'd1;
        end
        opcode_branch: begin
          case (ins.b.funct3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            3'd5:    taken = ($signed(a) >= $signed(b));
            3'd6:    taken = (a < b);
            default: taken = (a >= b);
          endcase
          pc = taken ? pc + b_imm : pc + 4;
        end
        default: pc = pc + 4;
      endcase
      model_regs[0] = '0;
    end
    expected_fetches.push_back(pc);
  endtask

  // Bus memory models
  // -----------------------------------------------
  always @(posedge clock) begin
    #1;
    if (ibus_rrequest && ibus_wait == 0) begin
      ibus_rresponse = 1'b1;
      ibus_rdata     = program_words[ibus_address[7:2]];
      ibus_wait      = rand_bits(2);
    end else begin
      ibus_rresponse = 1'b0;
      if (ibus_wait != 0) begin
        ibus_wait--;
      end
    end
    dbus_wresponse = 1'b0;
    if (dbus_wrequest) begin
      dbus_busy = 1'b1;
      dbus_wait = rand_bits(2);
    end
    if (dbus_busy) begin
      if (dbus_wait == 0) begin
        dbus_wresponse = 1'b1;
        dbus_busy      = 1'b0;
      end else begin
        dbus_wait--;
      end
    end
  end

  // Mid-cycle checks of fetches and stores
  always @(negedge clock) begin
    if (fetch_count > 0) begin
      assert (ibus_rrequest)
        else report_failure($sformatf("Error: ibus_rrequest is %h, expected %h",
                            ibus_rrequest, 1'b1));
    end
    // A fetch is accepted only with no write left unanswered
    if (reset_n && ibus_rresponse && !dbus_busy) begin
      fetch_index = (fetch_count < expected_fetches.size()) ? fetch_count
                                                            : expected_fetches.size() - 1;
      assert (ibus_address == expected_fetches[fetch_index])
        else report_failure($sformatf("Error: ibus_address is %h, expected %h",
                            ibus_address, expected_fetches[fetch_index]));
      fetch_count++;
    end
    if (reset_n && dbus_wrequest) begin
      assert (fetch_count > 0)
        else report_failure("A write request appeared before the first instruction response");
      assert (store_count < expected_stores.size())
        else report_failure("The core issued more stores than the program holds");
      assert (dbus_address == expected_stores[store_count].address)
        else report_failure($sformatf("Error: dbus_address is %h, expected %h",
                            dbus_address, expected_stores[store_count].address));
      assert (dbus_wstrobe == expected_stores[store_count].strobe)
        else report_failure($sformatf("Error: dbus_wstrobe is %h, expected %h",
                            dbus_wstrobe, expected_stores[store_count].strobe));
      for (int lane = 0; lane < 4; lane++) begin
        assert (!dbus_wstrobe[lane] ||
                dbus_wdata[8*lane +: 8] == expected_stores[store_count].data[8*lane +: 8])
          else report_failure($sformatf("Error: dbus_wdata is %h, expected %h",
                              dbus_wdata, expected_stores[store_count].data));
      end
      store_count++;
    end
  end

  initial begin
    reset_n        = 1'b0;
    ibus_rdata     = '0;
    ibus_rresponse = 1'b0;
    dbus_wresponse = 1'b0;
    lfsr_state     = 32'hd9cc;
    fetch_count    = 0;
    fetch_index    = 0;
    store_count    = 0;
    ibus_wait      = 0;
    dbus_wait      = 0;
    dbus_busy      = 1'b0;
    for (int index = 0; index < 63; index++) begin
      program_words[index] = make_instruction(index);
    end
    // jal x0, 0 holds the core at the end
    program_words[63] = 32'h0000006f;
    run_model();

    repeat (3) @(posedge clock);
    #1 reset_n = 1'b1;

    wait_cycles = 0;
    while ((fetch_count < expected_fetches.size() || store_count < expected_stores.size())
           && wait_cycles < 4000) begin
      @(posedge clock);
      wait_cycles++;
    end
    // Idle at the final jump so an extra store still shows up
    repeat (20) @(posedge clock);
    if (wait_cycles >= 4000) begin
      report_failure("Timed out before the program finished its fetches and stores");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// ==== verif/rvx_core_assertions.sv ====
/* RVX bus protocol assertions */
`timescale 1ns/10ps

module rvx_core_assertions (
  input logic        clock,
  input logic        reset_n,
  input logic [31:0] ibus_address,
  input logic        ibus_rrequest,
  input logic        ibus_rresponse,
  input logic        dbus_wrequest,
  input logic        dbus_wresponse
);

  // Fetch address held until answered
  assert property (@(posedge clock) disable iff (!reset_n)
    ibus_rrequest && !ibus_rresponse |=> $stable(ibus_address))
    else $error("ibus_address changed without a response");

  assert property (@(posedge clock) disable iff (!reset_n)
    dbus_wrequest && !dbus_wresponse |=> !dbus_wrequest)
    else $error("dbus_wrequest held longer than one cycle");

  // One outstanding write at a time
  assert property (@(posedge clock) disable iff (!reset_n)
    dbus_wrequest && !dbus_wresponse |=> !dbus_wrequest until dbus_wresponse)
    else $error("new write request before dbus_wresponse");

  assert property (@(posedge clock) !reset_n |=> !ibus_rrequest)
    else $error("ibus_rrequest active during reset");

endmodule

bind rvx_core rvx_core_assertions i_assertions (.*);

// ==== src/rvx_core.sv ====
/* RVX two-stage RV32I core */
`timescale 1ns/10ps

module rvx_core
  import rvx_pkg::*;
#(
  parameter word_t BOOT_ADDRESS = '0
) (
  input  logic    clock,
  input  logic    reset_n,
  // Instruction bus
  input  word_t   ibus_rdata,
  input  logic    ibus_rresponse,
  output word_t   ibus_address,
  output logic    ibus_rrequest,
  // Data bus
  input  logic    dbus_wresponse,
  output word_t   dbus_address,
  output word_t   dbus_wdata,
  output strobe_t dbus_wstrobe,
  output logic    dbus_wrequest
);

  logic       clock_enable;
  word_t      program_counter_s0;

  word_t      program_counter_s1;
  word_t      instruction_s1;
  ex_ctrl_t   ex_ctrl_s1;
  word_t      immediate_s1;
  logic       branch_s1;
  logic       jump_s1;
  logic       jalr_s1;
  logic       store_s1;
  logic [1:0] store_size_s1;
  word_t      rs1_data_s1;
  word_t      rs2_data_s1;
  word_t      target_address_s1;
  word_t      next_program_counter_s1;

  ex_ctrl_t   ex_ctrl_s2;
  word_t      rs1_data_s2;
  word_t      rs2_data_s2;
  word_t      immediate_s2;
  word_t      target_address_s2;
  word_t      program_counter_plus_4_s2;
  word_t      operand_b_s2;
  word_t      alu_output_s2;
  word_t      writeback_s2;

  rvx_bus_controller i_bus_controller (
    .clock              (clock),
    .reset_n            (reset_n),
    .ibus_rresponse     (ibus_rresponse),
    .dbus_wresponse     (dbus_wresponse),
    .program_counter_s0 (program_counter_s0),
    .ibus_rdata         (ibus_rdata),
    .store_s1           (store_s1),
    .store_size_s1      (store_size_s1),
    .target_address_s1  (target_address_s1),
    .rs2_data_s1        (rs2_data_s1),
    .ibus_address       (ibus_address),
    .ibus_rrequest      (ibus_rrequest),
    .dbus_address       (dbus_address),
    .dbus_wdata         (dbus_wdata),
    .dbus_wstrobe       (dbus_wstrobe),
    .dbus_wrequest      (dbus_wrequest),
    .clock_enable       (clock_enable),
    .instruction_s1     (instruction_s1)
  );

  // Stage 0 to 1
  // -----------------------------------------------
  assign program_counter_s0 = next_program_counter_s1;

  // Reset leaves a no-op one word before boot, so the first fetch is BOOT_ADDRESS
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      program_counter_s1 <= BOOT_ADDRESS - 32'd4;
    end else if (clock_enable) begin
      program_counter_s1 <= program_counter_s0;
    end
  end

  // Stage 1
  // -----------------------------------------------
  rvx_decoder i_decoder (
    .instruction_s1 (instruction_s1),
    .ex_ctrl_s1     (ex_ctrl_s1),
    .immediate_s1   (immediate_s1),
    .branch_s1      (branch_s1),
    .jump_s1        (jump_s1),
    .jalr_s1        (jalr_s1),
    .store_s1       (store_s1),
    .store_size_s1  (store_size_s1)
  );

  rvx_next_pc i_next_pc (
    .program_counter_s1      (program_counter_s1),
    .instruction_s1          (instruction_s1),
    .immediate_s1            (immediate_s1),
    .rs1_data_s1             (rs1_data_s1),
    .rs2_data_s1             (rs2_data_s1),
    .branch_s1               (branch_s1),
    .jump_s1                 (jump_s1),
    .jalr_s1                 (jalr_s1),
    .target_address_s1       (target_address_s1),
    .next_program_counter_s1 (next_program_counter_s1)
  );

  rvx_integer_file i_integer_file (
    .clock            (clock),
    .reset_n          (reset_n),
    .clock_enable     (clock_enable),
    .rs1_address_s1   (instruction_s1[19:15]),
    .rs2_address_s1   (instruction_s1[24:20]),
    .rs1_data_s1      (rs1_data_s1),
    .rs2_data_s1      (rs2_data_s1),
    .rd_address_s2    (ex_ctrl_s2.rd_address),
    .rd_data_s2       (writeback_s2),
    .write_request_s2 (ex_ctrl_s2.rd_write)
  );

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      ex_ctrl_s2 <= '0;
    end else if (clock_enable) begin
      ex_ctrl_s2 <= ex_ctrl_s1;
    end
  end

  always_ff @(posedge clock) begin
    if (clock_enable) begin
      rs1_data_s2               <= rs1_data_s1;
      rs2_data_s2               <= rs2_data_s1;
      immediate_s2              <= immediate_s1;
      target_address_s2         <= target_address_s1;
      program_counter_plus_4_s2 <= program_counter_s1 + 32'd4;
    end
  end

  // Stage 2
  // -----------------------------------------------
  assign operand_b_s2 = ex_ctrl_s2.use_immediate ? immediate_s2 : rs2_data_s2;

  rvx_alu i_alu (
    .alu_op_s2     (ex_ctrl_s2.alu_op),
    .operand_a_s2  (rs1_data_s2),
    .operand_b_s2  (operand_b_s2),
    .alu_output_s2 (alu_output_s2)
  );

  always_comb begin
    case (ex_ctrl_s2.wb_sel)
      wb_upper_imm:    writeback_s2 = immediate_s2;
      wb_target_adder: writeback_s2 = target_address_s2;
      wb_pc_plus_4:    writeback_s2 = program_counter_plus_4_s2;
      default:         writeback_s2 = alu_output_s2;
    endcase
  end

endmodule

// ==== src/rvx_bus_controller.sv ====
/* Bus sequencing and store alignment */
`timescale 1ns/10ps

module rvx_bus_controller
  import rvx_pkg::*;
(
  input  logic       clock,
  input  logic       reset_n,
  input  logic       ibus_rresponse,
  input  logic       dbus_wresponse,
  input  word_t      program_counter_s0,
  input  word_t      ibus_rdata,
  input  logic       store_s1,
  input  logic [1:0] store_size_s1,
  input  word_t      target_address_s1,
  input  word_t      rs2_data_s1,
  output word_t      ibus_address,
  output logic       ibus_rrequest,
  output word_t      dbus_address,
  output word_t      dbus_wdata,
  output strobe_t    dbus_wstrobe,
  output logic       dbus_wrequest,
  output logic       clock_enable,
  output word_t      instruction_s1
);

  // addi x0, x0, 0
  localparam word_t nop_instruction = 32'h00000013;

  logic                write_pending;
  logic [1:0]          byte_offset;
  strobe_t             size_mask;
  logic [7:0]          strobe_rotate;
  logic [2*xlen-1:0]   data_rotate;
  logic                store_issue;

  assign ibus_address = program_counter_s0;
  // Step only on a fetch response with the data bus free
  assign clock_enable = ibus_rresponse && (!write_pending || dbus_wresponse);
  assign store_issue  = clock_enable && store_s1;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      ibus_rrequest  <= 1'b0;
      instruction_s1 <= nop_instruction;
    end else begin
      ibus_rrequest <= 1'b1;
      if (clock_enable) begin
        instruction_s1 <= ibus_rdata;
      end
    end
  end

  // Store data alignment
  // -----------------------------------------------
  assign byte_offset = target_address_s1[1:0];

  always_comb begin
    case (store_size_s1)
      2'b00:   size_mask = 4'b0001;
      2'b01:   size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  // Rotate within the word so lanes wrap around
  assign strobe_rotate = {size_mask, size_mask} << byte_offset;
  assign data_rotate   = {rs2_data_s1, rs2_data_s1} << {byte_offset, 3'b000};

  // Write request and pending flag
  // -----------------------------------------------
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      dbus_wrequest <= 1'b0;
      write_pending <= 1'b0;
    end else begin
      dbus_wrequest <= store_issue;
      if (store_issue) begin
        write_pending <= 1'b1;
      end else if (dbus_wresponse) begin
        write_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (store_issue) begin
      dbus_address <= {target_address_s1[xlen-1:2], 2'b00};
      dbus_wdata   <= data_rotate[2*xlen-1:xlen];
      dbus_wstrobe <= strobe_rotate[7:4];
    end
  end

endmodule

// ==== src/rvx_next_pc.sv ====
/* Branch unit and next pc */
`timescale 1ns/10ps

module rvx_next_pc
  import rvx_pkg::*;
(
  input  word_t program_counter_s1,
  input  word_t instruction_s1,
  input  word_t immediate_s1,
  input  word_t rs1_data_s1,
  input  word_t rs2_data_s1,
  input  logic  branch_s1,
  input  logic  jump_s1,
  input  logic  jalr_s1,
  output word_t target_address_s1,
  output word_t next_program_counter_s1
);

  rv_instr_u instr;
  logic      take_branch;
  word_t     base_address;
  word_t     target_sum;

  assign instr = instruction_s1;

  always_comb begin
    case (instr.b.funct3)
      3'b000:  take_branch = (rs1_data_s1 == rs2_data_s1);
      3'b001:  take_branch = (rs1_data_s1 != rs2_data_s1);
      3'b100:  take_branch = ($signed(rs1_data_s1) < $signed(rs2_data_s1));
      3'b101:  take_branch = ($signed(rs1_data_s1) >= $signed(rs2_data_s1));
      3'b110:  take_branch = (rs1_data_s1 < rs2_data_s1);
      3'b111:  take_branch = (rs1_data_s1 >= rs2_data_s1);
      default: take_branch = 1'b0;
    endcase
  end

  // Register base for jalr and stores, pc relative otherwise
  assign base_address = (jalr_s1 || (instr.s.opcode == opcode_store)) ?
                        rs1_data_s1 : program_counter_s1;
  assign target_sum   = base_address + immediate_s1;

  assign target_address_s1 = {target_sum[xlen-1:1], target_sum[0] & !jalr_s1};

  assign next_program_counter_s1 = (jump_s1 || (branch_s1 && take_branch)) ?
                                   target_address_s1 : program_counter_s1 + 32'd4;

endmodule

// ==== src/rvx_decoder.sv ====
/* Instruction decoder */
`timescale 1ns/10ps

module rvx_decoder
  import rvx_pkg::*;
(
  input  word_t      instruction_s1,
  output ex_ctrl_t   ex_ctrl_s1,
  output word_t      immediate_s1,
  output logic       branch_s1,
  output logic       jump_s1,
  output logic       jalr_s1,
  output logic       store_s1,
  output logic [1:0] store_size_s1
);

  rv_instr_u instr;
  logic      alt_op;

  assign instr = instruction_s1;

  // funct7 bit 5 picks sub or sra, the immediate forms only have srai
  assign alt_op = instr.r.funct7[5] &&
                  ((instr.r.opcode == opcode_op) || (instr.r.funct3 == 3'b101));

  assign store_size_s1 = instr.s.funct3[1:0];

  always_comb begin
    ex_ctrl_s1.alu_op        = alu_op_e'({alt_op, instr.r.funct3});
    ex_ctrl_s1.use_immediate = 1'b0;
    ex_ctrl_s1.wb_sel        = wb_alu;
    ex_ctrl_s1.rd_write      = 1'b0;
    ex_ctrl_s1.rd_address    = instr.r.rd;
    immediate_s1 = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    branch_s1    = 1'b0;
    jump_s1      = 1'b0;
    jalr_s1      = 1'b0;
    store_s1     = 1'b0;

    case (instr.r.opcode)
      opcode_op: begin
        ex_ctrl_s1.rd_write = 1'b1;
      end
      opcode_op_imm: begin
        ex_ctrl_s1.use_immediate = 1'b1;
        ex_ctrl_s1.rd_write      = 1'b1;
      end
      opcode_lui, opcode_auipc: begin
        ex_ctrl_s1.wb_sel   = (instr.u.opcode == opcode_lui) ? wb_upper_imm : wb_target_adder;
        ex_ctrl_s1.rd_write = 1'b1;
        immediate_s1 = {instr.u.imm_31_12, 12'h000};
      end
      opcode_jal: begin
        ex_ctrl_s1.wb_sel   = wb_pc_plus_4;
        ex_ctrl_s1.rd_write = 1'b1;
        jump_s1 = 1'b1;
        immediate_s1 = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                        instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      opcode_jalr: begin
        ex_ctrl_s1.wb_sel   = wb_pc_plus_4;
        ex_ctrl_s1.rd_write = 1'b1;
        jump_s1 = 1'b1;
        jalr_s1 = 1'b1;
      end
      opcode_branch: begin
        branch_s1 = 1'b1;
        immediate_s1 = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                        instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      opcode_store: begin
        store_s1 = 1'b1;
        immediate_s1 = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      // Anything else retires as a no-op
      default: begin
        ex_ctrl_s1.rd_write = 1'b0;
      end
    endcase
  end

endmodule

// ==== src/rvx_integer_file.sv ====
/* Integer register file */
`timescale 1ns/10ps

module rvx_integer_file
  import rvx_pkg::*;
(
  input  logic      clock,
  input  logic      reset_n,
  input  logic      clock_enable,
  input  reg_addr_t rs1_address_s1,
  input  reg_addr_t rs2_address_s1,
  output word_t     rs1_data_s1,
  output word_t     rs2_data_s1,
  input  reg_addr_t rd_address_s2,
  input  word_t     rd_data_s2,
  input  logic      write_request_s2
);

  word_t registers [1:31];
  logic  write_active;

  // x0 is never stored
  assign write_active = write_request_s2 && (rd_address_s2 != '0);

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        registers[i] <= '0;
      end
    end else if (clock_enable && write_active) begin
      registers[rd_address_s2] <= rd_data_s2;
    end
  end

  // Pending stage 2 result wins over the stored value
  function automatic word_t read_port(input reg_addr_t address);
    word_t value;
    if (address == '0) begin
      value = '0;
    end else if (write_active && (address == rd_address_s2)) begin
      value = rd_data_s2;
    end else begin
      value = registers[address];
    end
    return value;
  endfunction

  always_comb begin
    rs1_data_s1 = read_port(rs1_address_s1);
    rs2_data_s1 = read_port(rs2_address_s1);
  end

endmodule

// ==== src/rvx_alu.sv ====
/* Integer ALU */
`timescale 1ns/10ps

module rvx_alu
  import rvx_pkg::*;
(
  input  alu_op_e alu_op_s2,
  input  word_t   operand_a_s2,
  input  word_t   operand_b_s2,
  output word_t   alu_output_s2
);

  logic [4:0] shift_amount;

  assign shift_amount = operand_b_s2[4:0];

  always_comb begin
    case (alu_op_s2)
      alu_add:  alu_output_s2 = operand_a_s2 + operand_b_s2;
      alu_sub:  alu_output_s2 = operand_a_s2 - operand_b_s2;
      alu_sll:  alu_output_s2 = operand_a_s2 << shift_amount;
      alu_slt:  alu_output_s2 = word_t'($signed(operand_a_s2) < $signed(operand_b_s2));
      alu_sltu: alu_output_s2 = word_t'(operand_a_s2 < operand_b_s2);
      alu_xor:  alu_output_s2 = operand_a_s2 ^ operand_b_s2;
      alu_srl:  alu_output_s2 = operand_a_s2 >> shift_amount;
      alu_sra:  alu_output_s2 = $signed(operand_a_s2) >>> shift_amount;
      alu_or:   alu_output_s2 = operand_a_s2 | operand_b_s2;
      alu_and:  alu_output_s2 = operand_a_s2 & operand_b_s2;
      default:  alu_output_s2 = operand_a_s2 + operand_b_s2;
    endcase
  end

endmodule

// ==== src/rvx_pkg.sv ====
/* RVX core shared types */
package rvx_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [3:0] strobe_t;

  typedef enum logic [6:0] {
    opcode_op     = 7'b0110011,
    opcode_op_imm = 7'b0010011,
    opcode_lui    = 7'b0110111,
    opcode_auipc  = 7'b0010111,
    opcode_jal    = 7'b1101111,
    opcode_jalr   = 7'b1100111,
    opcode_branch = 7'b1100011,
    opcode_store  = 7'b0100011
  } opcode_e;

  // Low three bits are funct3, bit 3 marks sub and sra
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu          = 2'd0,
    wb_upper_imm    = 2'd1,
    wb_target_adder = 2'd2,
    wb_pc_plus_4    = 2'd3
  } wb_sel_e;

  // Instruction formats
  // -----------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_format_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_format_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_format_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_format_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_format_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } j_format_t;

  typedef union packed {
    r_format_t r;
    i_format_t i;
    s_format_t s;
    b_format_t b;
    u_format_t u;
    j_format_t j;
  } rv_instr_u;

  // Stage 2 control
  typedef struct packed {
    alu_op_e   alu_op;
    logic      use_immediate;
    wb_sel_e   wb_sel;
    logic      rd_write;
    reg_addr_t rd_address;
  } ex_ctrl_t;

endpackage
